//--- Bender.yml
package:
  name: uart_phy

dependencies: {}

sources:
  # packages first, then the phys and the top level
  - src/uart_cfg_pkg.sv
  - src/uart_frame_pkg.sv
  - src/rx_ctrl_phy.sv
  - src/tx_ctrl_phy.sv
  - src/uart_phy_top.sv
  - target: test
    files:
      - tb/tb_uart_phy.sv

# top level uart_phy_top, testbench top tb_uart_phy

//--- sources.f
src/uart_cfg_pkg.sv
src/uart_frame_pkg.sv
src/rx_ctrl_phy.sv
src/tx_ctrl_phy.sv
src/uart_phy_top.sv
tb/tb_uart_phy.sv

//--- src/rx_ctrl_phy.sv
// uart receive phy with glitch filter, frame sequencer and mid-bit byte capture.
`timescale 1ns/10ps
`default_nettype none

module rx_ctrl_phy
	import uart_cfg_pkg::*;
	import uart_frame_pkg::*;
(
	input  logic                rx,
	input  logic [period_w-1:0] tbit_period,
	output logic                rx_vld,
	output logic [data_w-1:0]   rx_data,
	input  logic                clk_sys,
	input  logic                rst_n
);

	// ------------------------------
	// line filter
	// ------------------------------
	logic [filter_len-1:0] rx_hist; // first stage also samples the async line.
	logic                  rx_filt;
	logic                  rx_filt_d;
	logic                  rx_fall;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rx_hist   <= '1;
			rx_filt   <= 1'b1; // idle line is high.
			rx_filt_d <= 1'b1;
		end else begin
			rx_hist   <= {rx_hist[filter_len-2:0], rx};
			rx_filt_d <= rx_filt;
			if (rx_hist == '1)
				rx_filt <= 1'b1;
			else if (rx_hist == '0)
				rx_filt <= 1'b0;
		end
	end

	assign rx_fall = rx_filt_d & ~rx_filt;

	// ------------------------------
	// frame sequencer
	// ------------------------------
	logic [st_w-1:0]     rx_st;
	logic [period_w-1:0] bit_cnt;
	logic [period_w-1:0] mid_point;
	logic                bit_end;
	logic                in_frame;
	logic                in_data;

	assign in_frame  = (rx_st != st_idle) && (rx_st != st_done);
	assign in_data   = (rx_st >= st_d7) && (rx_st <= st_d0);
	assign bit_end   = (bit_cnt == tbit_period - period_w'(1));
	assign mid_point = {1'b0, tbit_period[period_w-1:1]} - period_w'(1);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			bit_cnt <= '0;
		else if (bit_end || !in_frame)
			bit_cnt <= '0;
		else
			bit_cnt <= bit_cnt + period_w'(1);
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rx_st <= st_idle;
		end else begin
			case (rx_st)
				st_idle:  rx_st <= rx_fall ? st_start : st_idle;
				st_start: rx_st <= bit_end ? st_d7 : st_start;
				st_d7:    rx_st <= bit_end ? st_d6 : st_d7;
				st_d6:    rx_st <= bit_end ? st_d5 : st_d6;
				st_d5:    rx_st <= bit_end ? st_d4 : st_d5;
				st_d4:    rx_st <= bit_end ? st_d3 : st_d4;
				st_d3:    rx_st <= bit_end ? st_d2 : st_d3;
				st_d2:    rx_st <= bit_end ? st_d1 : st_d2;
				st_d1:    rx_st <= bit_end ? st_d0 : st_d1;
				st_d0:    rx_st <= bit_end ? st_stop : st_d0;
				st_stop:  rx_st <= bit_end ? st_done : st_stop; // stop level not checked.
				st_done:  rx_st <= st_idle;
				default:  rx_st <= st_idle;
			endcase
		end
	end

	// ------------------------------
	// byte capture
	// ------------------------------
	logic [data_w-1:0] rx_work;

	// msb arrives first, so shift in from the bottom.
	always_ff @(posedge clk_sys) begin
		if (in_data && (bit_cnt == mid_point))
			rx_work <= {rx_work[data_w-2:0], rx_filt};
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rx_vld  <= 1'b0;
			rx_data <= '0;
		end else begin
			rx_vld <= (rx_st == st_done);
			if (rx_st == st_done)
				rx_data <= rx_work; // held until the next byte.
		end
	end

	// one pulse per byte.
	a_rx_vld_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rx_vld |=> !rx_vld);

	a_rx_period: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(rx_st != st_idle) |-> (tbit_period >= min_period));

endmodule

`default_nettype wire

//--- src/tx_ctrl_phy.sv
// uart transmit phy that serialises a byte into start, data and stop bits.
`timescale 1ns/10ps
`default_nettype none

module tx_ctrl_phy
	import uart_cfg_pkg::*;
	import uart_frame_pkg::*;
(
	input  logic                tx_start,
	input  logic [data_w-1:0]   tx_data,
	input  logic [period_w-1:0] tbit_period,
	output logic                tx,
	output logic                tx_busy,
	input  logic                clk_sys,
	input  logic                rst_n
);

	logic [st_w-1:0]           tx_st;
	logic [period_w-1:0]       bit_cnt;
	logic [$clog2(data_w)-1:0] bit_idx;
	logic [data_w-1:0]         tx_byte;
	logic                      bit_end;

	assign tx_busy = (tx_st != tx_idle);
	assign bit_end = (bit_cnt == tbit_period - period_w'(1));

	// ------------------------------
	// byte latch and bit timer
	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (tx_start && !tx_busy)
			tx_byte <= tx_data; // strobes while busy are dropped.
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			bit_cnt <= '0;
		else if (!tx_busy || bit_end)
			bit_cnt <= '0;
		else
			bit_cnt <= bit_cnt + period_w'(1);
	end

	// ------------------------------
	// frame sequencer
	// ------------------------------
	// tx is registered here so the line never glitches.
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			tx_st   <= tx_idle;
			bit_idx <= '0;
			tx      <= 1'b1;
		end else begin
			case (tx_st)
				tx_idle: begin
					if (tx_start) begin
						tx_st <= tx_start_bit;
						tx    <= 1'b0;
					end
				end
				tx_start_bit: begin
					if (bit_end) begin
						tx_st   <= uart_frame_pkg::tx_data;
						bit_idx <= '1; // msb first.
						tx      <= tx_byte[data_w-1];
					end
				end
				uart_frame_pkg::tx_data: begin
					if (bit_end) begin
						if (bit_idx == '0) begin
							tx_st <= tx_stop_bit;
							tx    <= 1'b1;
						end else begin
							bit_idx <= bit_idx - 1'b1;
							tx      <= tx_byte[bit_idx - 1'b1];
						end
					end
				end
				tx_stop_bit: begin
					if (bit_end)
						tx_st <= tx_idle; // busy drops after ten periods.
				end
				default: begin
					tx_st <= tx_idle;
					tx    <= 1'b1;
				end
			endcase
		end
	end

	a_tx_idle_high: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!tx_busy |-> tx);

	a_tx_period: assert property (@(posedge clk_sys) disable iff (!rst_n)
		tx_busy |-> (tbit_period >= min_period));

endmodule

`default_nettype wire

//--- src/uart_cfg_pkg.sv
// uart line timing constants shared by the receive and transmit phys.
`default_nettype none

package uart_cfg_pkg;

	// ------------------------------
	// bit period
	// ------------------------------
	localparam int unsigned period_w = 20; // period setting and cycle counters.

	// must exceed filter_len so the mid-bit sample lands inside the bit.
	localparam logic [period_w-1:0] min_period = period_w'(16);

	// ------------------------------
	// receive line filter
	// ------------------------------
	localparam int unsigned filter_len = 8; // equal samples before the line moves.

endpackage

`default_nettype wire

//--- src/uart_frame_pkg.sv
// uart frame format and the state codes of both frame sequencers.
`default_nettype none

package uart_frame_pkg;

	localparam int unsigned data_w = 8; // msb-first data bits per frame.
	localparam int unsigned st_w   = 4;

	// ------------------------------
	// receive sequencer
	// ------------------------------
	localparam logic [st_w-1:0] st_idle  = 4'h0;
	localparam logic [st_w-1:0] st_start = 4'h1;
	localparam logic [st_w-1:0] st_d7    = 4'h2;
	localparam logic [st_w-1:0] st_d6    = 4'h3;
	localparam logic [st_w-1:0] st_d5    = 4'h4;
	localparam logic [st_w-1:0] st_d4    = 4'h5;
	localparam logic [st_w-1:0] st_d3    = 4'h6;
	localparam logic [st_w-1:0] st_d2    = 4'h7;
	localparam logic [st_w-1:0] st_d1    = 4'h8;
	localparam logic [st_w-1:0] st_d0    = 4'h9;
	localparam logic [st_w-1:0] st_stop  = 4'ha;
	localparam logic [st_w-1:0] st_done  = 4'hf; // lasts one cycle and publishes the byte.

	// ------------------------------
	// transmit sequencer
	// ------------------------------
	localparam logic [st_w-1:0] tx_idle      = 4'h0;
	localparam logic [st_w-1:0] tx_start_bit = 4'h1;
	localparam logic [st_w-1:0] tx_data      = 4'h2;
	localparam logic [st_w-1:0] tx_stop_bit  = 4'h3;

endpackage

`default_nettype wire

//--- src/uart_phy_top.sv
// uart phy top level joining the receive and transmit phys on one clock and bit period.
`timescale 1ns/10ps
`default_nettype none

module uart_phy_top
	import uart_cfg_pkg::*;
	import uart_frame_pkg::*;
(
	input  logic                rx,
	input  logic [period_w-1:0] tbit_period, // hold steady while a frame runs.
	input  logic                tx_start,
	input  logic [data_w-1:0]   tx_data,
	output logic                rx_vld,
	output logic [data_w-1:0]   rx_data,
	output logic                tx,
	output logic                tx_busy,
	input  logic                clk_sys,
	input  logic                rst_n
);

	// ------------------------------
	// receive side
	// ------------------------------
	rx_ctrl_phy rx_ctrl_phy_i (
		.rx          (rx),
		.tbit_period (tbit_period),
		.rx_vld      (rx_vld),
		.rx_data     (rx_data),
		.clk_sys     (clk_sys),
		.rst_n       (rst_n)
	);

	// ------------------------------
	// transmit side
	// ------------------------------
	tx_ctrl_phy tx_ctrl_phy_i (
		.tx_start    (tx_start),
		.tx_data     (tx_data),
		.tbit_period (tbit_period),
		.tx          (tx),
		.tx_busy     (tx_busy),
		.clk_sys     (clk_sys),
		.rst_n       (rst_n)
	);

endmodule

`default_nettype wire

//--- tb/tb_uart_phy.sv
// uart phy testbench that replays the trace file against the top level and checks both lines.
`timescale 1ns/10ps
`default_nettype none

module tb_uart_phy
	import uart_cfg_pkg::*;
	import uart_frame_pkg::*;
();

	logic                clk_sys;
	logic                rst_n;
	logic                rx;
	logic [period_w-1:0] tbit_period;
	logic                tx_start;
	logic [data_w-1:0]   tx_data;
	logic                rx_vld;
	logic [data_w-1:0]   rx_data;
	logic                tx;
	logic                tx_busy;

	int          errors;
	int          timeouts;
	int          vld_seen; // rx_vld pulses seen so far.
	logic [31:0] lfsr;

	uart_phy_top uart_phy_top_i (
		.rx          (rx),
		.tbit_period (tbit_period),
		.tx_start    (tx_start),
		.tx_data     (tx_data),
		.rx_vld      (rx_vld),
		.rx_data     (rx_data),
		.tx          (tx),
		.tx_busy     (tx_busy),
		.clk_sys     (clk_sys),
		.rst_n       (rst_n)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ------------------------------
	// helpers
	// ------------------------------
	// taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	// advance to the falling edge where outputs are stable.
	task automatic tick();
		@(negedge clk_sys);
		if (rx_vld)
			vld_seen++;
	endtask

	task automatic check_val(input string name, input logic [31:0] act,
			input logic [31:0] exp);
		if (act !== exp) begin
			errors++;
			$display("Error at %0t: %s is %0h, expected %0h", $time, name, act, exp);
		end
	endtask

	// bit 0 is the start bit, bit 9 the stop bit.
	function automatic logic frame_bit(input logic [data_w-1:0] b, input int k);
		if (k == 0)
			return 1'b0;
		else if (k > data_w)
			return 1'b1;
		else
			return b[data_w-k];
	endfunction

	task automatic idle_gap();
		int extra;
		rand_bits(4, extra);
		repeat (int'(tbit_period) + extra) tick();
	endtask

	// ------------------------------
	// frame tasks
	// ------------------------------
	task automatic send_rx_byte(input logic [data_w-1:0] b, input logic [data_w-1:0] exp);
		int start_cnt;
		int wait_cnt;
		start_cnt = vld_seen;
		for (int k = 0; k <= data_w + 1; k++) begin
			rx = frame_bit(b, k);
			repeat (tbit_period) tick();
		end
		wait_cnt = 0;
		while (vld_seen == start_cnt && wait_cnt < 4 * int'(tbit_period)) begin
			tick();
			wait_cnt++;
		end
		if (vld_seen == start_cnt) begin
			timeouts++;
			$display("Timeout: no rx_vld after receiving byte %h", b);
		end else begin
			check_val("rx_data", rx_data, exp); // loaded on the rx_vld edge.
		end
		idle_gap();
		check_val("rx_vld pulses", vld_seen - start_cnt, 1);
	endtask

	task automatic send_glitch(input int width, input logic [data_w-1:0] exp);
		int start_cnt;
		start_cnt = vld_seen;
		if (width >= filter_len) begin
			errors++;
			$display("Trace glitch of %0d cycles is not shorter than the filter", width);
		end
		rx = 1'b0;
		repeat (width) tick();
		rx = 1'b1;
		repeat (12 * int'(tbit_period)) tick();
		check_val("rx_vld pulses", vld_seen - start_cnt, 0);
		check_val("rx_data", rx_data, exp);
	endtask

	task automatic send_tx_byte(input logic [data_w-1:0] b, input logic [data_w-1:0] exp,
			input logic late_strobe, input logic [data_w-1:0] other);
		int wait_cnt;
		int busy_n;
		int period;
		period   = int'(tbit_period);
		tx_start = 1'b1;
		tx_data  = b;
		tick();
		tx_start = 1'b0;
		wait_cnt = 0;
		while (!tx_busy && wait_cnt < 16) begin
			tick();
			wait_cnt++;
		end
		if (!tx_busy) begin
			timeouts++;
			$display("Timeout: tx_busy did not rise for byte %h", b);
			return;
		end
		busy_n = 0; // counted from tx_busy rising.
		while (tx_busy && busy_n < 12 * period) begin
			if (busy_n < 10 * period && busy_n % period == period / 2)
				check_val("tx", tx, frame_bit(exp, busy_n / period));
			if (late_strobe && busy_n == 2 * period) begin
				tx_start = 1'b1; // must be dropped while busy.
				tx_data  = other;
			end else begin
				tx_start = 1'b0;
			end
			tick();
			busy_n++;
		end
		tx_start = 1'b0;
		if (tx_busy) begin
			timeouts++;
			$display("Timeout: tx_busy did not fall for byte %h", b);
		end else begin
			check_val("tx_busy cycles", busy_n, 10 * period);
		end
		idle_gap();
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		int          fd;
		int          n;
		int          cmds;
		string       line;
		logic [7:0]  op;
		logic [31:0] arg_a;
		logic [31:0] arg_b;
		errors      = 0;
		timeouts    = 0;
		vld_seen    = 0;
		cmds        = 0;
		lfsr        = 32'h3908_57d2;
		rst_n       = 1'b0;
		rx          = 1'b1;
		tbit_period = min_period;
		tx_start    = 1'b0;
		tx_data     = '0;
		repeat (16) tick();
		rst_n = 1'b1;
		tick();
		check_val("tx", tx, 1);
		check_val("tx_busy", tx_busy, 0);
		check_val("rx_vld", rx_vld, 0);
		check_val("rx_data", rx_data, 0);

		fd = $fopen("tb/uart_phy_trace.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the trace file tb/uart_phy_trace.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%c %h %h", op, arg_a, arg_b);
				if (n >= 2 && op != "#") begin
					cmds++;
					case (op)
						"P": tbit_period = arg_a[period_w-1:0];
						"R": send_rx_byte(arg_a[data_w-1:0], arg_b[data_w-1:0]);
						"G": send_glitch(int'(arg_a), arg_b[data_w-1:0]);
						"T": send_tx_byte(arg_a[data_w-1:0], arg_b[data_w-1:0], 1'b0, '0);
						"B": send_tx_byte(arg_a[data_w-1:0], arg_a[data_w-1:0], 1'b1,
							arg_b[data_w-1:0]);
						default: begin
							errors++;
							$display("Unknown trace opcode %c", op);
						end
					endcase
				end
			end
			$fclose(fd);
			if (cmds == 0) begin
				errors++;
				$display("The trace file held no commands");
			end
		end

		$display("Finished %0d trace commands: %0d errors, %0d timeouts", cmds, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/uart_phy_trace.txt
# op a b, all hex. P period; R rx byte, expected rx_data; G low pulse cycles, expected rx_data.
# T tx byte, expected frame byte; B tx byte, second byte strobed while busy and ignored.
P 10
R a5 a5
R 3c 3c
G 05 3c
R 00 00
R ff ff
G 07 ff
T 96 96
T 01 01
B c3 5a
R 81 81
T 7e 7e
G 01 81
R 5a 5a
B 80 7f
P 1b
R 5a 5a
G 03 5a
T e1 e1
B 0f f0
R c6 c6
T 00 00
R 7f 7f
G 06 7f
T ff ff
R 12 12
B 55 aa
T 3d 3d
